// File: design/busPkg.sv
// Shared word types, bus source codes and ALU operations; every RTL file imports it.
`default_nettype none

package busPkg;

  // ##############################
  // Word widths
  // ##############################

  typedef logic [31:0] word_t;
  typedef logic [63:0] dword_t;
  typedef logic [4:0]  selCode_t;
  typedef logic [23:0] srcStrobes_t;
  typedef logic [15:0] gpLoad_t;

  localparam int NumGpRegs  = 16;
  localparam int NumSources = 24;

  // ##############################
  // Bus source codes
  // ##############################

  // Codes 0..15 select R0..R15.
  localparam selCode_t SrcHi     = 5'd16;
  localparam selCode_t SrcLo     = 5'd17;
  localparam selCode_t SrcZHigh  = 5'd18;
  localparam selCode_t SrcZLow   = 5'd19;
  localparam selCode_t SrcPc     = 5'd20;
  localparam selCode_t SrcMdr    = 5'd21;
  localparam selCode_t SrcInPort = 5'd22;
  localparam selCode_t SrcC      = 5'd23;

  // No strobe high, bus reads zero.
  localparam selCode_t SelNone   = 5'd31;

  // ALU operations.
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluMul = 3'd4
  } aluOp_t;

endpackage

`default_nettype wire

// File: design/busSrcIf.sv
// Bundle of all bus source words; registers drive it and the bus multiplexer reads it.
`timescale 1ns/1ps
`default_nettype none

interface busSrcIf import busPkg::*; ();

  word_t gpRegs [NumGpRegs];
  word_t hi;
  word_t lo;
  word_t zHigh;
  word_t zLow;
  word_t pc;
  word_t mdr;
  word_t inPort;
  // Driven from the top level port.
  word_t cSignExt;

  modport gpSide (
    output gpRegs
  );

  modport specialSide (
    output hi, lo, zHigh, zLow, pc, mdr, inPort
  );

  modport muxSide (
    input gpRegs,
    input hi, lo, zHigh, zLow, pc, mdr, inPort,
    input cSignExt
  );

endinterface

`default_nettype wire

// File: design/busEncoder.sv
// Turns the one-hot bus out strobes into the multiplexer select code.
`timescale 1ns/1ps
`default_nettype none

module busEncoder import busPkg::*; (
  input  wire              clk,
  input  wire srcStrobes_t outStrobes,
  output selCode_t         sel
);

  // Lowest index wins, so scan from the top down.
  always_comb begin
    sel = SelNone;
    for (int i = NumSources - 1; i >= 0; i--) begin
      if (outStrobes[i]) begin
        sel = selCode_t'(i);
      end
    end
  end

  // ##############################
  // Checks
  // ##############################

  // Only one source may drive the bus.
  oneSourceOnBus: assert property (
    @(posedge clk) $onehot0(outStrobes)
  ) else $error("Several bus out strobes high: %h", outStrobes);

endmodule

`default_nettype wire

// File: design/busMux.sv
// Bus multiplexer; picks the bus word out of the source bundle by select code.
`timescale 1ns/1ps
`default_nettype none

module busMux import busPkg::*; (
  busSrcIf.muxSide src,
  input  wire selCode_t sel,
  output word_t         busWord
);

  always_comb begin
    if (sel < selCode_t'(NumGpRegs)) begin
      // General registers.
      busWord = src.gpRegs[sel[3:0]];
    end else begin
      case (sel)
        SrcHi: begin
          busWord = src.hi;
        end
        SrcLo: begin
          busWord = src.lo;
        end
        SrcZHigh: begin
          busWord = src.zHigh;
        end
        SrcZLow: begin
          busWord = src.zLow;
        end
        SrcPc: begin
          busWord = src.pc;
        end
        SrcMdr: begin
          busWord = src.mdr;
        end
        SrcInPort: begin
          busWord = src.inPort;
        end
        SrcC: begin
          busWord = src.cSignExt;
        end
        // Unused codes and SelNone.
        default: begin
          busWord = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/gpRegFile.sv
// General register file R0..R15; each register loads from the bus on its own strobe.
`timescale 1ns/1ps
`default_nettype none

module gpRegFile import busPkg::*; (
  input  wire          clk,
  input  wire          rstN,
  input  wire gpLoad_t gpIn,
  input  wire word_t   busWord,
  busSrcIf.gpSide      src
);

  word_t regs [NumGpRegs];

  // ##############################
  // Registers
  // ##############################

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < NumGpRegs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumGpRegs; i++) begin
        if (gpIn[i]) begin
          regs[i] <= busWord;
        end
      end
    end
  end

  // Every register is a bus source.
  always_comb begin
    for (int i = 0; i < NumGpRegs; i++) begin
      src.gpRegs[i] = regs[i];
    end
  end

  // ##############################
  // Checks
  // ##############################

  // One destination register per bus cycle.
  oneGpLoad: assert property (
    @(posedge clk) disable iff (!rstN)
    $onehot0(gpIn)
  ) else $error("Several general register loads high: %h", gpIn);

endmodule

`default_nettype wire

// File: design/specialRegs.sv
// Special registers HI, LO, Y, Z, PC, MDR and InPort with their individual load rules.
`timescale 1ns/1ps
`default_nettype none

module specialRegs import busPkg::*; (
  input  wire         clk,
  input  wire         rstN,
  input  wire word_t  busWord,
  input  wire dword_t aluResult,
  input  wire         hiIn,
  input  wire         loIn,
  input  wire         yIn,
  input  wire         zIn,
  input  wire         pcIn,
  input  wire         incPc,
  input  wire         mdrIn,
  input  wire         readMem,
  input  wire         inPortIn,
  input  wire word_t  memData,
  input  wire word_t  inPortData,
  output word_t       yWord,
  busSrcIf.specialSide src
);

  word_t  hiReg;
  word_t  loReg;
  word_t  yReg;
  dword_t zReg;
  word_t  pcReg;
  word_t  mdrReg;
  word_t  inPortReg;

  // ##############################
  // Bus loaded registers
  // ##############################

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      hiReg <= '0;
      loReg <= '0;
      yReg  <= '0;
    end else begin
      if (hiIn) hiReg <= busWord;
      if (loIn) loReg <= busWord;
      if (yIn)  yReg  <= busWord;
    end
  end

  // ##############################
  // Z, PC, MDR and InPort
  // ##############################

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      zReg      <= '0;
      pcReg     <= '0;
      mdrReg    <= '0;
      inPortReg <= '0;
    end else begin
      // Full ALU result, both halves.
      if (zIn) zReg <= aluResult;
      // Explicit load beats increment.
      if (pcIn) begin
        pcReg <= busWord;
      end else if (incPc) begin
        pcReg <= pcReg + 32'd1;
      end
      if (mdrIn) begin
        mdrReg <= readMem ? memData : busWord;
      end
      if (inPortIn) inPortReg <= inPortData;
    end
  end

  assign yWord      = yReg;
  assign src.hi     = hiReg;
  assign src.lo     = loReg;
  assign src.zHigh  = zReg[63:32];
  assign src.zLow   = zReg[31:0];
  assign src.pc     = pcReg;
  assign src.mdr    = mdrReg;
  assign src.inPort = inPortReg;

  // Control should not load and increment PC together.
  pcLoadOrInc: assert property (
    @(posedge clk) disable iff (!rstN)
    !(pcIn && incPc)
  ) else $warning("pcIn and incPc both high, bus load kept");

endmodule

`default_nettype wire

// File: design/aluUnit.sv
// Combinational ALU over Y and the bus word; its 64-bit result is loaded into Z.
`timescale 1ns/1ps
`default_nettype none

module aluUnit import busPkg::*; (
  input  wire aluOp_t op,
  input  wire word_t  a,
  input  wire word_t  b,
  output dword_t      result
);

  logic signed [63:0] aExt;
  logic signed [63:0] bExt;
  logic signed [63:0] product;

  // Sign extended operands for the multiply.
  assign aExt    = {{32{a[31]}}, a};
  assign bExt    = {{32{b[31]}}, b};
  assign product = aExt * bExt;

  // ##############################
  // Operation select
  // ##############################

  always_comb begin
    case (op)
      aluAdd: begin
        result = {32'b0, word_t'(a + b)};
      end
      aluSub: begin
        result = {32'b0, word_t'(a - b)};
      end
      aluAnd: begin
        result = {32'b0, a & b};
      end
      aluOr: begin
        result = {32'b0, a | b};
      end
      // Full signed product, HI half in Z high.
      aluMul: begin
        result = dword_t'(product);
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/busDatapath.sv
// Top level of the single bus datapath; connects registers, ALU, encoder and bus mux.
`timescale 1ns/1ps
`default_nettype none

module busDatapath import busPkg::*; (
  input  wire              clk,
  input  wire              rstN,
  input  wire srcStrobes_t outStrobes,
  input  wire gpLoad_t     gpIn,
  input  wire              hiIn,
  input  wire              loIn,
  input  wire              yIn,
  input  wire              zIn,
  input  wire              pcIn,
  input  wire              incPc,
  input  wire              mdrIn,
  input  wire              readMem,
  input  wire              inPortIn,
  input  wire word_t       memData,
  input  wire word_t       inPortData,
  input  wire word_t       cSignExt,
  input  wire aluOp_t      aluOp,
  output word_t            busOut
);

  selCode_t sel;
  word_t    yWord;
  dword_t   aluResult;

  busSrcIf srcBus ();

  // Constant from the instruction register.
  assign srcBus.cSignExt = cSignExt;

  // ##############################
  // Bus path
  // ##############################

  busEncoder encoder (
    .clk        (clk),
    .outStrobes (outStrobes),
    .sel        (sel)
  );

  busMux mux (
    .src     (srcBus.muxSide),
    .sel     (sel),
    .busWord (busOut)
  );

  // ##############################
  // Registers and ALU
  // ##############################

  gpRegFile gpRegs (
    .clk     (clk),
    .rstN    (rstN),
    .gpIn    (gpIn),
    .busWord (busOut),
    .src     (srcBus.gpSide)
  );

  specialRegs special (
    .clk        (clk),
    .rstN       (rstN),
    .busWord    (busOut),
    .aluResult  (aluResult),
    .hiIn       (hiIn),
    .loIn       (loIn),
    .yIn        (yIn),
    .zIn        (zIn),
    .pcIn       (pcIn),
    .incPc      (incPc),
    .mdrIn      (mdrIn),
    .readMem    (readMem),
    .inPortIn   (inPortIn),
    .memData    (memData),
    .inPortData (inPortData),
    .yWord      (yWord),
    .src        (srcBus.specialSide)
  );

  aluUnit alu (
    .op     (aluOp),
    .a      (yWord),
    .b      (busOut),
    .result (aluResult)
  );

endmodule

`default_nettype wire

// File: tests/tbBusDatapath.sv
// Directed testbench for the bus datapath; compiled from tb.f, prints a pass or fail line.
`timescale 1ns/1ps
`default_nettype none

module tbBusDatapath import busPkg::*; ();

  localparam int ResetTimeout = 20;

  logic        clk;
  logic        rstN;
  srcStrobes_t outStrobes;
  gpLoad_t     gpIn;
  logic        hiIn;
  logic        loIn;
  logic        yIn;
  logic        zIn;
  logic        pcIn;
  logic        incPc;
  logic        mdrIn;
  logic        readMem;
  logic        inPortIn;
  word_t       memData;
  word_t       inPortData;
  word_t       cSignExt;
  aluOp_t      aluOp;
  word_t       busOut;

  logic [15:0] lfsrState;

  // Expected register contents.
  word_t  expGp [NumGpRegs];
  word_t  expHi;
  word_t  expLo;
  word_t  expMdr;
  word_t  expPc;
  dword_t expZ;

  busDatapath DUT (
    .clk        (clk),
    .rstN       (rstN),
    .outStrobes (outStrobes),
    .gpIn       (gpIn),
    .hiIn       (hiIn),
    .loIn       (loIn),
    .yIn        (yIn),
    .zIn        (zIn),
    .pcIn       (pcIn),
    .incPc      (incPc),
    .mdrIn      (mdrIn),
    .readMem    (readMem),
    .inPortIn   (inPortIn),
    .memData    (memData),
    .inPortData (inPortData),
    .cSignExt   (cSignExt),
    .aluOp      (aluOp),
    .busOut     (busOut)
  );

  always #2 clk = ~clk;

  // ##############################
  // Helpers
  // ##############################

  // Taps 16, 14, 13, 11.
  function automatic logic lfsrStep();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  function automatic word_t randomWord();
    word_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsrStep()};
    end
    return w;
  endfunction

  function automatic srcStrobes_t srcBit(selCode_t code);
    return srcStrobes_t'(1) << code;
  endfunction

  // Low half only for the logic and add ops, full signed product for multiply.
  function automatic dword_t aluModel(aluOp_t op, word_t a, word_t b);
    longint pa;
    longint pb;
    pa = longint'($signed(a));
    pb = longint'($signed(b));
    case (op)
      aluAdd:  return {32'h0, a + b};
      aluSub:  return {32'h0, a - b};
      aluAnd:  return {32'h0, a & b};
      aluOr:   return {32'h0, a | b};
      aluMul:  return dword_t'(pa * pb);
      default: return '0;
    endcase
  endfunction

  task automatic abortRun(string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic checkWord(string what, word_t expected, word_t actual);
    if (actual !== expected) begin
      abortRun($sformatf("Error: busOut (%s) expected %h got %h", what, expected, actual));
    end
  endtask

  task automatic setIdle();
    outStrobes <= '0;
    gpIn       <= '0;
    hiIn       <= 1'b0;
    loIn       <= 1'b0;
    yIn        <= 1'b0;
    zIn        <= 1'b0;
    pcIn       <= 1'b0;
    incPc      <= 1'b0;
    mdrIn      <= 1'b0;
    readMem    <= 1'b0;
    inPortIn   <= 1'b0;
  endtask

  // Puts one source on the bus; the caller adds load strobes in the same step.
  task automatic driveSource(selCode_t code);
    @(posedge clk);
    setIdle();
    outStrobes <= srcBit(code);
  endtask

  task automatic readBus(selCode_t code, word_t expected, string what);
    driveSource(code);
    @(negedge clk);
    checkWord(what, expected, busOut);
  endtask

  task automatic waitResetRelease();
    int cycles;
    cycles = 0;
    while (!rstN && cycles < ResetTimeout) begin
      @(posedge clk);
      cycles++;
    end
    if (!rstN) begin
      abortRun("Reset was never released");
    end
  endtask

  // ##############################
  // Tests
  // ##############################

  task automatic testReset();
    for (int i = 0; i < NumSources; i++) begin
      readBus(selCode_t'(i), '0, $sformatf("source %0d after reset", i));
    end
    @(posedge clk);
    setIdle();
    @(negedge clk);
    checkWord("no strobe high", '0, busOut);
  endtask

  task automatic testGpRegs();
    word_t w;
    for (int i = 0; i < NumGpRegs; i++) begin
      w = randomWord();
      @(posedge clk);
      setIdle();
      inPortData <= w;
      inPortIn   <= 1'b1;
      driveSource(SrcInPort);
      gpIn <= gpLoad_t'(1) << i;
      expGp[i] = w;
    end
    for (int i = 0; i < NumGpRegs; i++) begin
      readBus(selCode_t'(i), expGp[i], $sformatf("R%0d", i));
    end
    // Loaded registers stay off an idle bus.
    @(posedge clk);
    setIdle();
    @(negedge clk);
    checkWord("no strobe high after loads", '0, busOut);
  endtask

  task automatic testSpecialPaths();
    word_t w;
    w = randomWord();
    driveSource(SrcC);
    cSignExt <= w;
    hiIn     <= 1'b1;
    expHi = w;
    driveSource(selCode_t'(5));
    loIn <= 1'b1;
    expLo = expGp[5];
    readBus(SrcHi, expHi, "HI");
    readBus(SrcLo, expLo, "LO");
    // Memory read while R2 sits on the bus.
    w = randomWord();
    driveSource(selCode_t'(2));
    memData <= w;
    readMem <= 1'b1;
    mdrIn   <= 1'b1;
    expMdr = w;
    readBus(SrcMdr, expMdr, "MDR from memory");
    w = randomWord();
    driveSource(SrcC);
    cSignExt <= w;
    memData  <= randomWord();
    mdrIn    <= 1'b1;
    expMdr = w;
    readBus(SrcMdr, expMdr, "MDR from bus");
    w = randomWord();
    driveSource(SrcC);
    cSignExt <= w;
    @(negedge clk);
    checkWord("C source", w, busOut);
  endtask

  task automatic runAluOp(aluOp_t op, word_t a, word_t b);
    driveSource(SrcC);
    cSignExt <= a;
    yIn      <= 1'b1;
    driveSource(SrcC);
    cSignExt <= b;
    aluOp    <= op;
    zIn      <= 1'b1;
    expZ = aluModel(op, a, b);
    readBus(SrcZLow, expZ[31:0], $sformatf("Z low after %s", op.name()));
    readBus(SrcZHigh, expZ[63:32], $sformatf("Z high after %s", op.name()));
  endtask

  task automatic testAluToZ();
    aluOp_t ops [5];
    ops = '{aluAdd, aluSub, aluAnd, aluOr, aluMul};
    for (int i = 0; i < 5; i++) begin
      runAluOp(ops[i], randomWord(), randomWord());
    end
    // Signed corners.
    runAluOp(aluMul, 32'hFFFF_FFF6, 32'd7);
    runAluOp(aluMul, 32'h8000_0000, 32'h8000_0000);
  endtask

  task automatic testPc();
    word_t w;
    w = randomWord();
    driveSource(SrcC);
    cSignExt <= w;
    pcIn     <= 1'b1;
    expPc = w;
    readBus(SrcPc, expPc, "PC load");
    repeat (3) begin
      @(posedge clk);
      setIdle();
      incPc <= 1'b1;
      expPc = expPc + 32'd1;
    end
    readBus(SrcPc, expPc, "PC increment");
    w = randomWord();
    driveSource(SrcC);
    cSignExt <= w;
    pcIn     <= 1'b1;
    incPc    <= 1'b1;
    expPc = w;
    readBus(SrcPc, expPc, "PC load over increment");
  endtask

  // ##############################
  // Main sequence
  // ##############################

  initial begin
    clk        = 1'b0;
    rstN       = 1'b0;
    lfsrState  = 16'd20543;
    memData    = '0;
    inPortData = '0;
    cSignExt   = '0;
    aluOp      = aluAdd;
    setIdle();
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    waitResetRelease();
    testReset();
    testGpRegs();
    testSpecialPaths();
    testAluToZ();
    testPc();
    @(posedge clk);
    setIdle();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
design/busPkg.sv
design/busSrcIf.sv
design/busEncoder.sv
design/busMux.sv
design/gpRegFile.sv
design/specialRegs.sv
design/aluUnit.sv
design/busDatapath.sv
tests/tbBusDatapath.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; exits non-zero unless the run passed.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tbBusDatapath -o simBusDatapath &&
simOut="$(./obj_dir/simBusDatapath)"
echo "$simOut"
echo "$simOut" | grep -q "Test passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
